/* logic/st_consts.svh */
`ifndef ST_CONSTS_SVH
`define ST_CONSTS_SVH

// ------------------------------
// Tag space
// ------------------------------

// Store tag width and the tag count it spans
`define ST_TAG_W 5
`define ST_NUM_TAGS 32

// ------------------------------
// Retry address slice
// ------------------------------

// Address bits kept per tag in the retry memory
`define ST_EA_KEEP_HI 31
`define ST_EA_KEEP_LO 7

// ------------------------------
// Command encodings
// ------------------------------

// DMA write opcodes, plain and no-snoop variant
`define ST_OP_DMA_W 8'h20
`define ST_OP_DMA_W_N 8'h24

// Marker bits inside the afutag field
`define ST_AFUTAG_STORE_BIT 13
`define ST_AFUTAG_RETRY_BIT 9

`endif

/* logic/st_pkg.sv */
`default_nettype none

`include "st_consts.svh"

package st_pkg;

  // ------------------------------
  // Tags
  // ------------------------------

  // Store tag as handed out by the arbiter
  typedef logic [`ST_TAG_W-1:0] tag_t;

  // One bit per tag, used for the tag-available pulses
  typedef logic [`ST_NUM_TAGS-1:0] tag_vec_t;

  // ------------------------------
  // Command fields
  // ------------------------------

  // Data length code, 3 means 256 bytes
  typedef logic [1:0] dl_t;

  // Cache-line address
  typedef logic [63:6] ea_t;

  // Address slice kept per tag for retries
  typedef logic [`ST_EA_KEEP_HI:`ST_EA_KEEP_LO] ea_keep_t;

  // Tag field sent with the command
  typedef logic [15:0] afutag_t;

  // Address field of the command bus
  typedef logic [67:0] ea_obj_t;

  // Command opcode
  typedef logic [7:0] opcode_t;

  // ------------------------------
  // Retry sequencer
  // ------------------------------

  // One-hot states, one bit per state
  typedef enum logic [4:0] {
    RTRY_IDLE         = 5'b00001,
    RTRY_WAIT_BACKOFF = 5'b00010,
    RTRY_REQ          = 5'b00100,
    RTRY_WAIT_GNT     = 5'b01000,
    RTRY_ABORT        = 5'b10000
  } rtry_state_t;

endpackage

`default_nettype wire

/* logic/st_retry_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module st_retry_seq
(
  input  logic clock,
  input  logic reset,
  input  logic rtry_start,
  input  logic rtry_immediate,
  input  logic rtry_backoff,
  input  logic rtry_abort,
  input  logic rtry_backoff_done,
  input  logic rtry_gnt,
  output logic rtry_req
);

  // Current and next state
  st_pkg::rtry_state_t state_q;
  st_pkg::rtry_state_t state_d;

  // ------------------------------
  // Next state and request
  // ------------------------------

  always_comb
  begin
    // Hold by default, no request
    state_d  = state_q;
    rtry_req = 1'b0;
    case (state_q)
      st_pkg::RTRY_IDLE:
      begin
        // Start pulses only count here
        if (rtry_start)
        begin
          if (rtry_immediate)
          begin
            state_d  = st_pkg::RTRY_REQ;
            rtry_req = 1'b1;
          end
          else if (rtry_backoff)
          begin
            // Backoff may already be over
            if (rtry_backoff_done)
            begin
              state_d  = st_pkg::RTRY_REQ;
              rtry_req = 1'b1;
            end
            else
            begin
              state_d = st_pkg::RTRY_WAIT_BACKOFF;
            end
          end
          else if (rtry_abort)
          begin
            state_d = st_pkg::RTRY_ABORT;
          end
        end
      end
      st_pkg::RTRY_WAIT_BACKOFF:
      begin
        // Timer still running
        if (rtry_backoff_done)
        begin
          state_d  = st_pkg::RTRY_REQ;
          rtry_req = 1'b1;
        end
      end
      st_pkg::RTRY_REQ:
      begin
        // Memory read issued, go wait for the arbiter
        state_d = st_pkg::RTRY_WAIT_GNT;
      end
      st_pkg::RTRY_WAIT_GNT:
      begin
        // No limit on how long the arbiter holds off
        if (rtry_gnt)
        begin
          state_d = st_pkg::RTRY_IDLE;
        end
      end
      st_pkg::RTRY_ABORT:
      begin
        state_d = st_pkg::RTRY_IDLE;
      end
      default:
      begin
        // Any non-one-hot value recovers to idle
        state_d = st_pkg::RTRY_IDLE;
      end
    endcase
  end

  // ------------------------------
  // State register
  // ------------------------------

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state_q <= st_pkg::RTRY_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* logic/st_retry_ea_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_consts.svh"

module st_retry_ea_ram
(
  input  logic          clock,
  input  logic          st_gnt,
  input  st_pkg::tag_t  st_tag,
  input  st_pkg::ea_t   st_ea,
  input  logic          rtry_req,
  input  st_pkg::tag_t  rtry_tag,
  input  logic          size_256,
  output st_pkg::ea_t   rtry_ea
);

  // Address slice per tag
  st_pkg::ea_keep_t mem [`ST_NUM_TAGS];

  // Read port
  st_pkg::tag_t     rd_addr;
  st_pkg::ea_keep_t rd_q;

  // Bit 7 of the rebuilt address
  logic             ea_bit7;

  // ------------------------------
  // Write at new grants
  // ------------------------------

  always_ff @(posedge clock)
  begin
    if (st_gnt)
    begin
      mem[st_tag] <= st_ea[`ST_EA_KEEP_HI:`ST_EA_KEEP_LO];
    end
  end

  // ------------------------------
  // Read at retry requests
  // ------------------------------

  // 256B stores live in the even entry only
  assign rd_addr = {rtry_tag[`ST_TAG_W-1:1], rtry_tag[0] & ~size_256};

  // Data held until the next request
  always_ff @(posedge clock)
  begin
    if (rtry_req)
    begin
      rd_q <= mem[rd_addr];
    end
  end

  // Odd tag in 256B mode retries the upper half
  assign ea_bit7 = rd_q[7] | (size_256 & rtry_tag[0]);

  // Upper bits from the live address, middle from memory
  assign rtry_ea = {st_ea[63:`ST_EA_KEEP_HI+1], rd_q[`ST_EA_KEEP_HI:8], ea_bit7, 1'b0};

endmodule

`default_nettype wire

/* logic/st_cmd_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_consts.svh"

module st_cmd_issue
(
  input  logic              clock,
  input  st_pkg::dl_t       st_size,
  input  logic              type_sel,
  input  logic              st_gnt,
  input  st_pkg::tag_t      st_tag,
  input  st_pkg::ea_t       st_ea,
  input  logic              rtry_gnt,
  input  st_pkg::tag_t      rtry_tag,
  input  st_pkg::dl_t       rtry_dl,
  input  st_pkg::ea_t       rtry_ea,
  output logic              size_256,
  output logic              cmd_valid,
  output st_pkg::opcode_t   cmd_opcode,
  output st_pkg::ea_obj_t   cmd_ea_obj,
  output st_pkg::afutag_t   cmd_afutag,
  output st_pkg::dl_t       cmd_dl
);

  // Registered store size
  st_pkg::dl_t     size_q;

  // Opcode picked by command type
  st_pkg::opcode_t opcode;

  // ------------------------------
  // Store size
  // ------------------------------

  // Sampled every cycle
  always_ff @(posedge clock)
  begin
    size_q <= st_size;
  end

  assign size_256 = (size_q == 2'b11);

  // No-snoop variant on request
  assign opcode = type_sel ? `ST_OP_DMA_W_N : `ST_OP_DMA_W;

  // ------------------------------
  // Command forming
  // ------------------------------

  always_comb
  begin
    // Idle bus is all zeros
    cmd_valid  = 1'b0;
    cmd_opcode = '0;
    cmd_ea_obj = '0;
    cmd_afutag = '0;
    cmd_dl     = '0;
    if (rtry_gnt)
    begin
      // Retry wins if both grants ever meet
      cmd_valid                        = 1'b1;
      cmd_opcode                       = opcode;
      cmd_ea_obj                       = {4'b0, rtry_ea, 6'b0};
      cmd_afutag[15:14]                = rtry_dl;
      cmd_afutag[`ST_AFUTAG_STORE_BIT] = 1'b1;
      cmd_afutag[`ST_AFUTAG_RETRY_BIT] = 1'b1;
      cmd_afutag[`ST_TAG_W-1:0]        = rtry_tag;
      cmd_dl                           = rtry_dl;
    end
    else if (st_gnt)
    begin
      // New store, tag zero-extended into the low field
      cmd_valid                        = 1'b1;
      cmd_opcode                       = opcode;
      cmd_ea_obj                       = {4'b0, st_ea, 6'b0};
      cmd_afutag[15:14]                = size_q;
      cmd_afutag[`ST_AFUTAG_STORE_BIT] = 1'b1;
      cmd_afutag[`ST_TAG_W-1:0]        = st_tag;
      cmd_dl                           = size_q;
    end
  end

endmodule

`default_nettype wire

/* logic/st_resp_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_consts.svh"

module st_resp_tracker
(
  input  logic               clock,
  input  logic               reset,
  input  logic               size_256,
  input  logic               resp_valid,
  input  st_pkg::tag_t       resp_tag,
  input  st_pkg::dl_t        resp_dl,
  input  logic               rtry_start,
  input  logic               rtry_abort,
  input  st_pkg::tag_t       rtry_tag,
  input  st_pkg::dl_t        rtry_dl,
  output st_pkg::tag_vec_t   tag_avail
);

  localparam int NUM_PAIRS = `ST_NUM_TAGS / 2;

  // Tags with bit 0 dropped in 256B mode
  st_pkg::tag_t     resp_idx;
  st_pkg::tag_t     abort_idx;

  // Abort counts as a completed store
  logic             abort_valid;

  // Decoded one-hot sources
  st_pkg::tag_vec_t resp_vec;
  st_pkg::tag_vec_t abort_vec;

  // One half bit per even pair
  logic [NUM_PAIRS-1:0] half_q;
  logic [NUM_PAIRS-1:0] half_d;

  // ------------------------------
  // Decode
  // ------------------------------

  assign abort_valid = rtry_start & rtry_abort;

  assign resp_idx  = {resp_tag[`ST_TAG_W-1:1], resp_tag[0] & ~size_256};
  assign abort_idx = {rtry_tag[`ST_TAG_W-1:1], rtry_tag[0] & ~size_256};

  assign resp_vec  = resp_valid ? (st_pkg::tag_vec_t'(1'b1) << resp_idx) : '0;
  assign abort_vec = abort_valid ? (st_pkg::tag_vec_t'(1'b1) << abort_idx) : '0;

  // ------------------------------
  // Per pair tracking
  // ------------------------------

  for (genvar i = 0; i < NUM_PAIRS; i++)
  begin : g_pair
    always_comb
    begin
      half_d[i] = half_q[i];
      // Half bits only move in 256B mode
      if (size_256)
      begin
        if (resp_vec[2*i] && abort_vec[2*i])
        begin
          // Two 128B halves at once, pair complete
          half_d[i] = 1'b0;
        end
        else if (resp_vec[2*i])
        begin
          half_d[i] = (resp_dl == 2'b11) ? 1'b0 : ~half_q[i];
        end
        else if (abort_vec[2*i])
        begin
          half_d[i] = (rtry_dl == 2'b11) ? 1'b0 : ~half_q[i];
        end
      end
    end

    // Even tag frees once the half bit is back at 0
    assign tag_avail[2*i] = (resp_vec[2*i] | abort_vec[2*i]) & (~half_d[i] | ~size_256);

    // Odd tags never decode in 256B mode
    assign tag_avail[2*i+1] = resp_vec[2*i+1] | abort_vec[2*i+1];
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      half_q <= '0;
    end
    else
    begin
      half_q <= half_d;
    end
  end

endmodule

`default_nettype wire

/* logic/st_engine_top.sv */
`timescale 1ns/1ps
`default_nettype none

module st_engine_top
(
  input  logic               clock,
  input  logic               reset,
  input  st_pkg::dl_t        st_size,
  input  logic               type_sel,
  input  logic               st_gnt,
  input  st_pkg::tag_t       st_tag,
  input  st_pkg::ea_t        st_ea,
  input  logic               rtry_start,
  input  logic               rtry_immediate,
  input  logic               rtry_backoff,
  input  logic               rtry_abort,
  input  logic               rtry_backoff_done,
  input  st_pkg::tag_t       rtry_tag,
  input  st_pkg::dl_t        rtry_dl,
  input  logic               rtry_gnt,
  input  logic               resp_valid,
  input  st_pkg::tag_t       resp_tag,
  input  st_pkg::dl_t        resp_dl,
  output logic               rtry_req,
  output logic               cmd_valid,
  output st_pkg::opcode_t    cmd_opcode,
  output st_pkg::ea_obj_t    cmd_ea_obj,
  output st_pkg::afutag_t    cmd_afutag,
  output st_pkg::dl_t        cmd_dl,
  output logic               size_256,
  output st_pkg::tag_vec_t   tag_avail
);

  // Rebuilt retry address
  st_pkg::ea_t rtry_ea;

  // ------------------------------
  // Processing part
  // ------------------------------

  st_retry_seq st_retry_seq_inst (
    .clock             (clock),
    .reset             (reset),
    .rtry_start        (rtry_start),
    .rtry_immediate    (rtry_immediate),
    .rtry_backoff      (rtry_backoff),
    .rtry_abort        (rtry_abort),
    .rtry_backoff_done (rtry_backoff_done),
    .rtry_gnt          (rtry_gnt),
    .rtry_req          (rtry_req)
  );

  st_retry_ea_ram st_retry_ea_ram_inst (
    .clock    (clock),
    .st_gnt   (st_gnt),
    .st_tag   (st_tag),
    .st_ea    (st_ea),
    .rtry_req (rtry_req),
    .rtry_tag (rtry_tag),
    .size_256 (size_256),
    .rtry_ea  (rtry_ea)
  );

  // ------------------------------
  // Output side
  // ------------------------------

  st_cmd_issue st_cmd_issue_inst (
    .clock      (clock),
    .st_size    (st_size),
    .type_sel   (type_sel),
    .st_gnt     (st_gnt),
    .st_tag     (st_tag),
    .st_ea      (st_ea),
    .rtry_gnt   (rtry_gnt),
    .rtry_tag   (rtry_tag),
    .rtry_dl    (rtry_dl),
    .rtry_ea    (rtry_ea),
    .size_256   (size_256),
    .cmd_valid  (cmd_valid),
    .cmd_opcode (cmd_opcode),
    .cmd_ea_obj (cmd_ea_obj),
    .cmd_afutag (cmd_afutag),
    .cmd_dl     (cmd_dl)
  );

  // ------------------------------
  // Input side
  // ------------------------------

  st_resp_tracker st_resp_tracker_inst (
    .clock      (clock),
    .reset      (reset),
    .size_256   (size_256),
    .resp_valid (resp_valid),
    .resp_tag   (resp_tag),
    .resp_dl    (resp_dl),
    .rtry_start (rtry_start),
    .rtry_abort (rtry_abort),
    .rtry_tag   (rtry_tag),
    .rtry_dl    (rtry_dl),
    .tag_avail  (tag_avail)
  );

endmodule

`default_nettype wire

/* tests/st_engine_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module st_retry_seq_sva
(
  input logic                clock,
  input logic                reset,
  input st_pkg::rtry_state_t state,
  input logic                rtry_req
);

  // State register holds exactly one set bit
  state_onehot: assert property (@(posedge clock) disable iff (reset) $onehot(state))
    else $error("Retry sequencer state is not one-hot");

  // Request never stretches past one cycle
  req_single: assert property (@(posedge clock) disable iff (reset) rtry_req |=> !rtry_req)
    else $error("Retry request lasted two cycles");

  // Only idle and wait-backoff may raise it
  req_source: assert property (@(posedge clock) disable iff (reset)
    rtry_req |-> (state == st_pkg::RTRY_IDLE || state == st_pkg::RTRY_WAIT_BACKOFF))
    else $error("Retry request raised from a wrong state");

endmodule

// ------------------------------
// Attach to every sequencer
// ------------------------------

bind st_retry_seq st_retry_seq_sva st_retry_seq_sva_inst
(
  .clock    (clock),
  .reset    (reset),
  .state    (state_q),
  .rtry_req (rtry_req)
);

`default_nettype wire

/* tests/st_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_consts.svh"

module st_engine_tb;

  localparam int NUM_PAIRS   = `ST_NUM_TAGS / 2;
  localparam int NUM_STORES  = 24;
  localparam int NUM_RETRIES = 16;
  localparam int NUM_ABORTS  = 8;
  localparam int NUM_RESPS   = 24;
  // Fill pass, random traffic and the four direct pair cases
  localparam int NUM_TESTS   = `ST_NUM_TAGS + NUM_STORES + NUM_RETRIES + NUM_ABORTS
                               + 2 * NUM_RESPS + 4;
  localparam int WATCHDOG_NS = NUM_TESTS * 40 * 40;

  // DUT inputs
  logic                 clock;
  logic                 reset;
  st_pkg::dl_t          st_size;
  logic                 type_sel;
  logic                 st_gnt;
  st_pkg::tag_t         st_tag;
  st_pkg::ea_t          st_ea;
  logic                 rtry_start;
  logic                 rtry_immediate;
  logic                 rtry_backoff;
  logic                 rtry_abort;
  logic                 rtry_backoff_done;
  st_pkg::tag_t         rtry_tag;
  st_pkg::dl_t          rtry_dl;
  logic                 rtry_gnt;
  logic                 resp_valid;
  st_pkg::tag_t         resp_tag;
  st_pkg::dl_t          resp_dl;

  // DUT outputs
  logic                 rtry_req;
  logic                 cmd_valid;
  st_pkg::opcode_t      cmd_opcode;
  st_pkg::ea_obj_t      cmd_ea_obj;
  st_pkg::afutag_t      cmd_afutag;
  st_pkg::dl_t          cmd_dl;
  logic                 size_256;
  st_pkg::tag_vec_t     tag_avail;

  // Galois LFSR state
  logic [31:0]          lfsr_state;

  // Model of stored address bits, read register and half bits
  st_pkg::ea_keep_t     model_mem [`ST_NUM_TAGS];
  st_pkg::ea_keep_t     model_rd;
  logic [NUM_PAIRS-1:0] model_half;
  // Store size once it has settled in the DUT
  st_pkg::dl_t          model_size;
  // Retry request due in the current cycle
  logic                 exp_req;

  st_engine_top st_engine_top_inst (.*);

  // 40 ns clock
  always
  begin
    clock = 1'b0;
    #20;
    clock = 1'b1;
    #20;
  end

  // ------------------------------
  // Reference functions
  // ------------------------------

  // One LFSR step per bit with bits shifting in at the bottom
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0])
      begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end
      else
      begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return r;
  endfunction

  function automatic st_pkg::opcode_t ref_opcode(input logic sel);
    return sel ? `ST_OP_DMA_W_N : `ST_OP_DMA_W;
  endfunction

  // Size on top, store marker, optional retry marker, tag in the low nine bits
  function automatic st_pkg::afutag_t ref_afutag(input st_pkg::dl_t dl, input logic retry,
                                                 input st_pkg::tag_t tag);
    st_pkg::afutag_t a;
    a = '0;
    a[15:14] = dl;
    a[`ST_AFUTAG_STORE_BIT] = 1'b1;
    a[`ST_AFUTAG_RETRY_BIT] = retry;
    a[8:0] = 9'(tag);
    return a;
  endfunction

  function automatic st_pkg::ea_obj_t ref_ea_obj(input st_pkg::ea_t ea);
    return {4'b0, ea, 6'b0};
  endfunction

  // Live upper half, stored middle, bit 7 forced for odd 256B tags
  function automatic st_pkg::ea_t ref_retry_ea(input st_pkg::ea_t cur,
                                               input st_pkg::ea_keep_t kept,
                                               input st_pkg::tag_t tag, input logic big);
    st_pkg::ea_t r;
    r = cur;
    r[31:7] = kept;
    r[7] = kept[7] | (big & tag[0]);
    r[6] = 1'b0;
    return r;
  endfunction

  // Tag pulses for a response and an abort together with the half bits they leave
  function automatic st_pkg::tag_vec_t ref_tags(input logic rv, input st_pkg::tag_t rt,
                                                input st_pkg::dl_t rdl, input logic av,
                                                input st_pkg::tag_t at, input st_pkg::dl_t adl,
                                                input logic big,
                                                input logic [NUM_PAIRS-1:0] half_in,
                                                output logic [NUM_PAIRS-1:0] half_out);
    st_pkg::tag_vec_t v;
    int rp;
    int ap;
    v = '0;
    half_out = half_in;
    rp = int'(rt[`ST_TAG_W-1:1]);
    ap = int'(at[`ST_TAG_W-1:1]);
    if (!big)
    begin
      if (rv)
      begin
        v[rt] = 1'b1;
      end
      if (av)
      begin
        v[at] = 1'b1;
      end
    end
    else if (rv && av && rp == ap)
    begin
      // Both halves of one pair in the same cycle
      v[2*rp] = 1'b1;
      half_out[rp] = 1'b0;
    end
    else
    begin
      if (rv)
      begin
        half_out[rp] = (rdl == 2'b11) ? 1'b0 : ~half_out[rp];
        v[2*rp] = ~half_out[rp];
      end
      if (av)
      begin
        half_out[ap] = (adl == 2'b11) ? 1'b0 : ~half_out[ap];
        v[2*ap] = ~half_out[ap];
      end
    end
    return v;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_cmd(input logic gv, input st_pkg::opcode_t gop,
                             input st_pkg::ea_obj_t gea, input st_pkg::afutag_t gtag,
                             input st_pkg::dl_t gdl, input logic ev,
                             input st_pkg::opcode_t eop, input st_pkg::ea_obj_t eea,
                             input st_pkg::afutag_t etag, input st_pkg::dl_t edl);
    if (gv !== ev || gop !== eop || gea !== eea || gtag !== etag || gdl !== edl)
    begin
      stop_run($sformatf("[ERROR] %0d ns: command v=%0b op=%h ea=%h tag=%h dl=%0d, %s",
                         $time, gv, gop, gea, gtag, gdl,
                         $sformatf("expected v=%0b op=%h ea=%h tag=%h dl=%0d",
                                   ev, eop, eea, etag, edl)));
    end
  endtask

  task automatic compare_tags(input st_pkg::tag_vec_t got, input st_pkg::tag_vec_t exp);
    if (got !== exp)
    begin
      stop_run($sformatf("[ERROR] %0d ns: tag_avail %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      stop_run($sformatf("[ERROR] %0d ns: %s is %0b, expected %0b", $time, name, got, exp));
    end
  endtask

  task automatic check_req(input logic got, input logic exp);
    if (exp && got !== 1'b1)
    begin
      stop_run($sformatf("At %0d ns the retry request did not come", $time));
    end
    else if (!exp && got !== 1'b0)
    begin
      stop_run($sformatf("At %0d ns a retry request came when none was due", $time));
    end
  endtask

  // ------------------------------
  // Compare process
  // ------------------------------

  // Falling edge sees the inputs settled since they move 1 ns after the rising edge
  always @(negedge clock)
  begin : compare_outputs
    logic                 big;
    logic                 ev;
    st_pkg::opcode_t      eop;
    st_pkg::ea_obj_t      eea;
    st_pkg::afutag_t      etag;
    st_pkg::dl_t          edl;
    st_pkg::tag_vec_t     eavail;
    logic [NUM_PAIRS-1:0] next_half;
    st_pkg::tag_t         rd_tag;
    if (reset)
    begin
      model_half = '0;
    end
    else
    begin
      big = (model_size == 2'b11);
      ev = rtry_gnt | st_gnt;
      eop = '0;
      eea = '0;
      etag = '0;
      edl = '0;
      if (rtry_gnt)
      begin
        eop = ref_opcode(type_sel);
        eea = ref_ea_obj(ref_retry_ea(st_ea, model_rd, rtry_tag, big));
        etag = ref_afutag(rtry_dl, 1'b1, rtry_tag);
        edl = rtry_dl;
      end
      else if (st_gnt)
      begin
        eop = ref_opcode(type_sel);
        eea = ref_ea_obj(st_ea);
        etag = ref_afutag(model_size, 1'b0, st_tag);
        edl = model_size;
      end
      compare_cmd(cmd_valid, cmd_opcode, cmd_ea_obj, cmd_afutag, cmd_dl,
                  ev, eop, eea, etag, edl);
      eavail = ref_tags(resp_valid, resp_tag, resp_dl, rtry_start & rtry_abort,
                        rtry_tag, rtry_dl, big, model_half, next_half);
      compare_tags(tag_avail, eavail);
      check_req(rtry_req, exp_req);
      if (st_gnt | rtry_gnt | resp_valid | rtry_start)
      begin
        compare_flag("size_256", size_256, big);
      end
      // Advance the model to the next edge
      if (st_gnt)
      begin
        model_mem[st_tag] = st_ea[`ST_EA_KEEP_HI:`ST_EA_KEEP_LO];
      end
      if (exp_req)
      begin
        rd_tag = rtry_tag;
        if (big)
        begin
          rd_tag[0] = 1'b0;
        end
        model_rd = model_mem[rd_tag];
      end
      model_half = next_half;
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  // Step to the drive point and drop all pulses
  task automatic next_cycle();
    @(posedge clock);
    #1;
    st_gnt = 1'b0;
    rtry_start = 1'b0;
    rtry_immediate = 1'b0;
    rtry_backoff = 1'b0;
    rtry_abort = 1'b0;
    rtry_gnt = 1'b0;
    resp_valid = 1'b0;
    exp_req = 1'b0;
  endtask

  // New size needs two quiet cycles to reach size_q
  task automatic set_size(input st_pkg::dl_t s);
    st_size = s;
    next_cycle();
    next_cycle();
    model_size = s;
  endtask

  task automatic new_store(input st_pkg::tag_t tag);
    st_gnt = 1'b1;
    st_tag = tag;
    st_ea = st_pkg::ea_t'({rand_bits(26), rand_bits(32)});
    type_sel = 1'(rand_bits(1));
    next_cycle();
  endtask

  task automatic retry(input logic backoff, input st_pkg::tag_t tag, input st_pkg::dl_t dl);
    int gap;
    int wait_cycles;
    gap = 2 + int'(rand_bits(2));
    wait_cycles = int'(rand_bits(2));
    rtry_start = 1'b1;
    rtry_immediate = ~backoff;
    rtry_backoff = backoff;
    rtry_tag = tag;
    rtry_dl = dl;
    // Zero wait means the timer ran out before the start
    rtry_backoff_done = backoff && (wait_cycles == 0);
    exp_req = !backoff || (wait_cycles == 0);
    next_cycle();
    if (backoff && wait_cycles != 0)
    begin
      repeat (wait_cycles)
      begin
        next_cycle();
      end
      rtry_backoff_done = 1'b1;
      exp_req = 1'b1;
      next_cycle();
    end
    rtry_backoff_done = 1'b0;
    // A start while busy is dropped
    rtry_start = 1'b1;
    rtry_immediate = 1'b1;
    next_cycle();
    repeat (gap - 2)
    begin
      next_cycle();
    end
    rtry_gnt = 1'b1;
    next_cycle();
  endtask

  task automatic abort(input st_pkg::tag_t tag, input st_pkg::dl_t dl);
    rtry_start = 1'b1;
    rtry_abort = 1'b1;
    rtry_tag = tag;
    rtry_dl = dl;
    next_cycle();
    // Abort state returns to idle
    next_cycle();
  endtask

  task automatic respond(input st_pkg::tag_t tag, input st_pkg::dl_t dl);
    resp_valid = 1'b1;
    resp_tag = tag;
    resp_dl = dl;
    next_cycle();
  endtask

  task automatic respond_with_abort(input st_pkg::tag_t rt, input st_pkg::dl_t rdl,
                                    input st_pkg::tag_t at, input st_pkg::dl_t adl);
    resp_valid = 1'b1;
    resp_tag = rt;
    resp_dl = rdl;
    abort(at, adl);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial
  begin
    lfsr_state = 32'hc50;
    reset = 1'b1;
    st_size = 2'b00;
    type_sel = 1'b0;
    st_gnt = 1'b0;
    st_tag = '0;
    st_ea = '0;
    rtry_start = 1'b0;
    rtry_immediate = 1'b0;
    rtry_backoff = 1'b0;
    rtry_abort = 1'b0;
    rtry_backoff_done = 1'b0;
    rtry_tag = '0;
    rtry_dl = '0;
    rtry_gnt = 1'b0;
    resp_valid = 1'b0;
    resp_tag = '0;
    resp_dl = '0;
    exp_req = 1'b0;
    model_size = 2'b00;
    repeat (2)
    begin
      @(posedge clock);
    end
    #1;
    reset = 1'b0;
    // Size held two cycles before traffic
    next_cycle();
    next_cycle();
    // Every entry written so no retry reads an empty slot
    for (int i = 0; i < `ST_NUM_TAGS; i++)
    begin
      new_store(st_pkg::tag_t'(i));
    end
    for (int i = 0; i < NUM_STORES; i++)
    begin
      // Each random store runs at its own size
      set_size(st_pkg::dl_t'(rand_bits(2)));
      new_store(st_pkg::tag_t'(rand_bits(`ST_TAG_W)));
    end
    // Immediate and backoff retries with the second half at 256 bytes
    set_size(2'b00);
    for (int i = 0; i < NUM_RETRIES; i++)
    begin
      if (i == NUM_RETRIES / 2)
      begin
        set_size(2'b11);
      end
      retry(i[0], st_pkg::tag_t'(rand_bits(`ST_TAG_W)), st_pkg::dl_t'(rand_bits(2)));
    end
    // Aborts and responses below 256 bytes
    set_size(2'b01);
    for (int i = 0; i < NUM_ABORTS; i++)
    begin
      abort(st_pkg::tag_t'(rand_bits(`ST_TAG_W)), st_pkg::dl_t'(rand_bits(2)));
    end
    for (int i = 0; i < NUM_RESPS; i++)
    begin
      respond(st_pkg::tag_t'(rand_bits(`ST_TAG_W)), st_pkg::dl_t'(rand_bits(2)));
    end
    // Pair tracking at 256 bytes
    set_size(2'b11);
    respond(st_pkg::tag_t'(4), 2'b11);
    respond(st_pkg::tag_t'(6), 2'b01);
    respond(st_pkg::tag_t'(7), 2'b01);
    respond_with_abort(st_pkg::tag_t'(8), 2'b01, st_pkg::tag_t'(9), 2'b01);
    for (int i = 0; i < NUM_RESPS; i++)
    begin
      if (rand_bits(1) != 0)
      begin
        abort(st_pkg::tag_t'(rand_bits(`ST_TAG_W)), st_pkg::dl_t'(rand_bits(2)));
      end
      else
      begin
        respond(st_pkg::tag_t'(rand_bits(`ST_TAG_W)), st_pkg::dl_t'(rand_bits(2)));
      end
    end
    next_cycle();
    $display("Everything OK");
    $finish;
  end

  // Watchdog sized from the test count
  initial
  begin
    #(WATCHDOG_NS);
    stop_run("Timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/st_pkg.sv
logic/st_retry_seq.sv
logic/st_retry_ea_ram.sv
logic/st_cmd_issue.sv
logic/st_resp_tracker.sv
logic/st_engine_top.sv
tests/st_engine_sva.sv
tests/st_engine_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the store engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module st_engine_tb -Mdir obj_dir -o st_engine_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/st_engine_sim > sim.log 2>&1
sim_status=$?
cat sim.log

# The log decides the result, a bad exit status also counts
if grep -q "Something failed" sim.log; then
  echo "Result: FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Result: PASS"
exit 0
